//--- thiele_cpu.f
+incdir+src
src/thiele_isa_pkg.sv
src/thiele_result_pkg.sv
src/thiele_control.sv
src/thiele_partition_table.sv
src/thiele_xor_matrix.sv
src/thiele_csr_bank.sv
src/thiele_cpu.sv
testbench/thiele_cpu_assert.sv
testbench/tb_thiele_cpu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only if the log shows the pass line
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f thiele_cpu.f \
    --top-module tb_thiele_cpu -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim 2>&1 | tee sim.log \
    || echo "build or run ended with an error"
grep -qx "TB PASSED" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

//--- testbench/tb_thiele_cpu.sv
// Testbench for the partition bookkeeping processor
// Runs a directed and random program against a reference model, with a logic engine model
`timescale 1ns/10ps
`include "thiele_macros.svh"

module tb_thiele_cpu import thiele_isa_pkg::*, thiele_result_pkg::*;;

    logic        clk, rst_n;
    logic [31:0] instr_data, pc;
    logic [31:0] cert_addr, status, error_code, partition_ops, mdl_ops, info_gain, mu_total;
    logic        logic_req_valid, logic_req_ready, logic_rsp_valid, logic_rsp_ready;
    logic [31:0] logic_addr, logic_data;

    thiele_cpu i_dut (.*);

    // Program and per-instruction test number
    logic [31:0] prog[$];
    int          test_of[$];
    string       test_name[7] = '{"pnew_mdlacc", "merge_xfer_fill", "xor_rank", "emit",
                                  "lassert", "unknown_ops", "random_program"};
    int          err_cnt, test_err, tests_ok, tests_bad, prog_len;
    logic        run_done;
    logic [31:0] rng_state, last_pc;

    // Reference state
    int unsigned     m_sizes[16];
    int unsigned     m_next, m_cur;
    logic [6:0]      m_rows[4];
    logic [31:0]     e_cert, e_status, e_err, e_pops, e_mdl, e_gain;
    longint unsigned e_acc;

    always #50 clk = ~clk;

    function logic [31:0] rand_next();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Engine answer depends on the whole request address
    function automatic logic [31:0] engine_answer(input logic [31:0] addr);
        return (addr * 32'h9E3779B1) ^ 32'h5A5A_0000;
    endfunction

    task automatic add_instr(input int t, input logic [7:0] op, input int a, input int b);
        prog.push_back({op, 8'(a), 8'(b), 8'h00});
        test_of.push_back(t);
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            err_cnt++;
            test_err++;
        end
    endtask

    // ============================================================
    // Reference model applied once per retired instruction
    // ============================================================
    function void ref_step(input logic [31:0] w);
        logic [7:0]      op, a, b;
        int unsigned     id, sz, v, n, sum;
        longint unsigned cost;
        logic [6:0]      tmp;
        op = w[31:24];
        a  = w[23:16];
        b  = w[15:8];
        case (op)
            8'h00: begin
                if (m_next < 16) begin
                    m_sizes[m_next] = {a, b};
                    m_cur = m_next;
                    m_next++;
                    e_status = 1;
                    e_pops++;
                end else e_err = 2;
            end
            8'h02: begin
                sum = m_sizes[a[3:0]] + m_sizes[b[3:0]];
                if (a >= m_next || b >= m_next || a == b || m_next >= 16) e_err = 5;
                else if (sum > 1024) e_err = 4;
                else begin
                    m_sizes[a] = 0;
                    m_sizes[b] = 0;
                    m_sizes[m_next] = sum;
                    m_cur = m_next;
                    m_next++;
                    e_status = 3;
                    e_pops++;
                end
            end
            8'h03: e_cert = engine_answer({16'h0, a, b});
            8'h05: begin
                id = (a == 0) ? m_cur : a;
                if (a != 0 && a >= m_next) e_err = 7;
                else begin
                    sz = m_sizes[id];
                    v  = sz;
                    n  = 0;
                    while (v != 0) begin
                        n++;
                        v = v >> 1;
                    end
                    cost = (sz == 0) ? 1 : longint'(n) * sz;
                    if (e_acc + cost > 64'hFFFF_FFFF) e_err = 6;
                    else begin
                        e_acc += cost;
                        e_mdl++;
                        e_status = 5;
                    end
                end
            end
            8'h07: begin
                if (a >= m_next || b >= m_next) e_err = 9;
                else if (m_sizes[a] != 0 && m_sizes[b] < 1024) begin
                    m_sizes[b]++;
                    e_status = 6;
                end else e_err = 8;
            end
            8'h0B: begin
                if (a >= 4 || b >= 4) e_err = 32'hA;
                else begin
                    m_rows[a] = m_rows[a] ^ m_rows[b];
                    e_status = 8;
                    e_pops++;
                end
            end
            8'h0C: begin
                if (a >= 4 || b >= 4) e_err = 32'hB;
                else begin
                    tmp = m_rows[a];
                    m_rows[a] = m_rows[b];
                    m_rows[b] = tmp;
                    e_status = 9;
                    e_pops++;
                end
            end
            8'h0D: e_status = 32'(m_rows[0][0]) + 32'(m_rows[1][0]) +
                              32'(m_rows[2][0]) + 32'(m_rows[3][0]);
            8'h0E: begin
                e_gain   = (a == 0) ? 32'(b) : e_gain + 1;
                e_status = (32'(a) << 24) + (32'(b) << 16);
            end
            default: e_err = 1;
        endcase
    endfunction

    task automatic build_program();
        logic [7:0] ops[12] = '{8'h00, 8'h02, 8'h03, 8'h05, 8'h07, 8'h0B, 8'h0C, 8'h0D,
                                8'h0E, 8'h01, 8'h06, 8'h0F};
        // Sizes 0, 1, large, then explicit and bad ids
        add_instr(0, 8'h00, 0, 0);
        add_instr(0, 8'h05, 0, 0);
        add_instr(0, 8'h00, 0, 1);
        add_instr(0, 8'h05, 0, 0);
        add_instr(0, 8'h00, 255, 255);
        add_instr(0, 8'h05, 0, 0);
        add_instr(0, 8'h05, 1, 0);
        add_instr(0, 8'h05, 2, 0);
        add_instr(0, 8'h05, 9, 0);
        add_instr(0, 8'h00, 3, 0);
        add_instr(0, 8'h05, 4, 0);
        // Merge and transfer, then fill the table
        add_instr(1, 8'h02, 1, 2);
        add_instr(1, 8'h02, 4, 4);
        add_instr(1, 8'h02, 3, 4);
        add_instr(1, 8'h02, 1, 9);
        add_instr(1, 8'h07, 5, 1);
        add_instr(1, 8'h07, 2, 5);
        add_instr(1, 8'h07, 7, 1);
        add_instr(1, 8'h07, 3, 4);
        for (int i = 0; i < 12; i++) add_instr(1, 8'h00, 0, i + 2);
        add_instr(1, 8'h02, 1, 5);
        // XOR rows from the reset pattern
        add_instr(2, 8'h0D, 0, 0);
        add_instr(2, 8'h0B, 1, 0);
        add_instr(2, 8'h0D, 0, 0);
        add_instr(2, 8'h0C, 0, 2);
        add_instr(2, 8'h0D, 0, 0);
        // Row 0 now holds the old row 2, so the swap shows in this rank
        add_instr(2, 8'h0B, 3, 0);
        add_instr(2, 8'h0D, 0, 0);
        add_instr(2, 8'h0B, 4, 0);
        add_instr(2, 8'h0C, 1, 7);
        add_instr(2, 8'h0D, 0, 0);
        add_instr(3, 8'h0E, 0, 5);
        add_instr(3, 8'h0E, 2, 3);
        add_instr(3, 8'h0E, 1, 0);
        add_instr(3, 8'h05, 0, 0);
        for (int i = 0; i < 6; i++) add_instr(4, 8'h03, i * 37, 255 - i * 11);
        foreach (ops[i]) if (i >= 9) add_instr(5, ops[i], 1, 2);
        add_instr(5, 8'h04, 0, 0);
        add_instr(5, 8'hFF, 3, 3);
        // Random mix with a few unknown opcodes
        for (int i = 0; i < 60; i++) begin
            add_instr(6, ops[rand_next() % 12], int'(rand_next() % 18), int'(rand_next() % 18));
        end
        prog_len = prog.size();
    endtask

    // Program fetch and stimulus on the falling edge
    always @(negedge clk) begin
        instr_data <= ((pc >> 2) < prog_len) ? prog[pc >> 2] : 32'hFF00_0000;
    end

    // Logic engine model with random delays on both channels
    initial begin
        logic [31:0] held;
        int          d;
        logic_req_ready = 1'b0;
        logic_rsp_valid = 1'b0;
        logic_data      = '0;
        forever begin
            @(negedge clk);
            if (logic_req_valid) begin
                d = int'(rand_next() % 8);
                repeat (d) @(negedge clk);
                held            = logic_addr;
                logic_req_ready = 1'b1;
                @(negedge clk);
                logic_req_ready = 1'b0;
                d = int'(rand_next() % 8);
                repeat (d) @(negedge clk);
                logic_data      = engine_answer(held);
                logic_rsp_valid = 1'b1;
                // Answer held until the CPU is ready for it
                while (!logic_rsp_ready) @(negedge clk);
                @(negedge clk);
                logic_rsp_valid = 1'b0;
            end
        end
    end

    // ============================================================
    // Compare on each retirement
    // ============================================================
    always @(negedge clk) begin
        int idx;
        if (rst_n && !run_done && pc != last_pc) begin
            idx = int'(last_pc >> 2);
            ref_step(prog[idx]);
            check_value("cert_addr", cert_addr, e_cert);
            check_value("status", status, e_status);
            check_value("error_code", error_code, e_err);
            check_value("partition_ops", partition_ops, e_pops);
            check_value("mdl_ops", mdl_ops, e_mdl);
            check_value("info_gain", info_gain, e_gain);
            check_value("mu_total", mu_total, 32'(e_acc) + e_gain);
            last_pc = pc;
            if (idx == prog_len - 1 || test_of[idx + 1] != test_of[idx]) begin
                $display("test %0d %s: %s (%0d errors)", test_of[idx],
                         test_name[test_of[idx]], (test_err == 0) ? "pass" : "fail", test_err);
                if (test_err == 0) tests_ok++;
                else tests_bad++;
                test_err = 0;
            end
            if (idx == prog_len - 1) run_done = 1'b1;
        end
    end

    // Watchdog sized from program length and the longest engine delay
    initial begin
        wait (prog_len > 0);
        #((12 + 14) * prog_len * 2 * 100);
        $display("Timeout: the program did not finish in the allowed time");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        instr_data = '0;
        run_done = 1'b0;
        rng_state = 32'd9732;
        err_cnt = 0;
        test_err = 0;
        tests_ok = 0;
        tests_bad = 0;
        last_pc = '0;
        foreach (m_sizes[i]) m_sizes[i] = 0;
        m_next = 1;
        m_cur = 0;
        m_rows = '{7'b0_101001, 7'b1_010010, 7'b1_100100, 7'b0_000011};
        {e_cert, e_status, e_err, e_pops, e_mdl, e_gain} = '0;
        e_acc = 0;
        build_program();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        wait (run_done);
        $display("tests passed %0d, tests failed %0d, mismatches %0d", tests_ok, tests_bad,
                 err_cnt);
        if (err_cnt == 0 && tests_bad == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/thiele_cpu_assert.sv
// Concurrent checks on the sequencer outputs
// Bound into every thiele_control instance
`timescale 1ns/10ps

module thiele_cpu_assert (
    input logic        clk,
    input logic        rst_n,
    input logic [31:0] pc,
    input logic        logic_req_valid,
    input logic        logic_req_ready,
    input logic [31:0] logic_addr,
    input logic        logic_rsp_ready
);

    // Request held until accepted
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        logic_req_valid && !logic_req_ready |=> logic_req_valid && $stable(logic_addr))
        else $error("request dropped or changed before ready");

    // Sequential fetch only
    a_pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(pc) |-> pc == $past(pc) + 32'd4)
        else $error("pc moved by other than 4");

    // Engine quiet in reset
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !logic_req_valid && !logic_rsp_ready)
        else $error("logic engine control active in reset");

endmodule

bind thiele_control thiele_cpu_assert i_assert (.*);

//--- src/thiele_cpu.sv
// Top level of the multi-cycle partition bookkeeping processor
// Connects sequencer, execution units and CSR bank
`timescale 1ns/10ps
`include "thiele_macros.svh"

module thiele_cpu import thiele_isa_pkg::*, thiele_result_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    // Instruction port, addressed by pc
    input  logic [`THIELE_WORD_W-1:0] instr_data,
    output logic [`THIELE_WORD_W-1:0] pc,
    // Status outputs
    output logic [`THIELE_WORD_W-1:0] cert_addr,
    output logic [`THIELE_WORD_W-1:0] status,
    output logic [`THIELE_WORD_W-1:0] error_code,
    output logic [`THIELE_WORD_W-1:0] partition_ops,
    output logic [`THIELE_WORD_W-1:0] mdl_ops,
    output logic [`THIELE_WORD_W-1:0] info_gain,
    output logic [`THIELE_WORD_W-1:0] mu_total,
    // Logic engine, valid/ready on both channels
    output logic                      logic_req_valid,
    input  logic                      logic_req_ready,
    output logic [`THIELE_WORD_W-1:0] logic_addr,
    input  logic                      logic_rsp_valid,
    output logic                      logic_rsp_ready,
    input  logic [`THIELE_WORD_W-1:0] logic_data
);

    // Instruction broadcast and unit results
    instr_t                    exec_instr;
    logic                      exec_fire;
    logic                      opcode_err;
    logic                      cert_we;
    logic [`THIELE_WORD_W-1:0] cert_data;
    unit_result_t              part_result;
    unit_result_t              xor_result;

    thiele_control i_control (.*);

    thiele_partition_table i_partition_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .exec_instr  (exec_instr),
        .exec_fire   (exec_fire),
        .part_result (part_result)
    );

    thiele_xor_matrix i_xor_matrix (
        .clk        (clk),
        .rst_n      (rst_n),
        .exec_instr (exec_instr),
        .exec_fire  (exec_fire),
        .xor_result (xor_result)
    );

    thiele_csr_bank i_csr_bank (.*);

endmodule

//--- src/thiele_csr_bank.sv
// Status, error, certificate and counter registers plus the cost accumulator
// Applies unit results, EMIT and unknown opcodes on the execute strobe
`timescale 1ns/10ps
`include "thiele_macros.svh"

module thiele_csr_bank import thiele_isa_pkg::*, thiele_result_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  instr_t                    exec_instr,
    input  logic                      exec_fire,
    input  logic                      opcode_err,
    input  unit_result_t              part_result,
    input  unit_result_t              xor_result,
    input  logic                      cert_we,
    input  logic [`THIELE_WORD_W-1:0] cert_data,
    output logic [`THIELE_WORD_W-1:0] cert_addr,
    output logic [`THIELE_WORD_W-1:0] status,
    output logic [`THIELE_WORD_W-1:0] error_code,
    output logic [`THIELE_WORD_W-1:0] partition_ops,
    output logic [`THIELE_WORD_W-1:0] mdl_ops,
    output logic [`THIELE_WORD_W-1:0] info_gain,
    output logic [`THIELE_WORD_W-1:0] mu_total
);

    unit_result_t              res;
    logic [`THIELE_WORD_W-1:0] mu_acc;
    logic [`THIELE_WORD_W:0]   mu_sum;

    // Units decode disjoint opcodes, at most one hits
    assign res      = part_result.hit ? part_result : xor_result;
    assign mu_sum   = {1'b0, mu_acc} + {1'b0, res.cost};
    assign mu_total = mu_acc + info_gain;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cert_addr     <= '0;
            status        <= '0;
            error_code    <= '0;
            partition_ops <= '0;
            mdl_ops       <= '0;
            info_gain     <= '0;
            mu_acc        <= '0;
        end else begin
            // Engine answer for LASSERT
            if (cert_we) begin
                cert_addr <= cert_data;
            end
            if (exec_fire) begin
                if (opcode_err) begin
                    error_code <= ERR_OPCODE;
                end else if (exec_instr.opcode == EMIT) begin
                    info_gain <= (exec_instr.op_a == 8'd0) ?
                                 `THIELE_WORD_W'(exec_instr.op_b) : info_gain + 1'b1;
                    status    <= {exec_instr.op_a, exec_instr.op_b, 16'h0};
                end else if (res.hit) begin
                    if (!res.ok) begin
                        error_code <= res.error;
                    end else if (!res.cost_valid) begin
                        status <= res.status;
                    end else if (mu_sum[`THIELE_WORD_W]) begin
                        // Cost would wrap the accumulator
                        error_code <= ERR_MU_OVERFLOW;
                    end else begin
                        mu_acc  <= mu_sum[`THIELE_WORD_W-1:0];
                        mdl_ops <= mdl_ops + 1'b1;
                        status  <= res.status;
                    end
                    if (res.ok && res.count_part) begin
                        partition_ops <= partition_ops + 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- src/thiele_xor_matrix.sv
// XOR bit matrix with per-row parity: row add, row swap and a simple rank
// Result is combinational from present contents, rows commit on the execute strobe
`timescale 1ns/10ps
`include "thiele_macros.svh"

module thiele_xor_matrix import thiele_isa_pkg::*, thiele_result_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  instr_t       exec_instr,
    input  logic         exec_fire,
    output unit_result_t xor_result
);

    // Parity kept alongside its columns so row ops move both together
    typedef struct packed {
        logic                         parity;
        logic [`THIELE_XOR_COLS-1:0]  cols;
    } xor_row_t;

    xor_row_t   rows [`THIELE_XOR_ROWS];
    logic [1:0] t_idx, s_idx;
    logic       rows_ok;
    logic       add_en, swap_en;

    assign t_idx   = exec_instr.op_a[1:0];
    assign s_idx   = exec_instr.op_b[1:0];
    assign rows_ok = (exec_instr.op_a < `THIELE_XOR_ROWS) &&
                     (exec_instr.op_b < `THIELE_XOR_ROWS);

    always_comb begin
        xor_result = '0;
        add_en     = 1'b0;
        swap_en    = 1'b0;
        case (exec_instr.opcode)
            XOR_ADD: begin
                xor_result.hit        = 1'b1;
                xor_result.ok         = rows_ok;
                xor_result.status     = XOR_ADD_OK;
                xor_result.count_part = rows_ok;
                xor_result.error      = rows_ok ? error_code_e'(0) : ERR_XOR_ADD_ROW;
                add_en                = rows_ok;
            end
            XOR_SWAP: begin
                xor_result.hit        = 1'b1;
                xor_result.ok         = rows_ok;
                xor_result.status     = XOR_SWAP_OK;
                xor_result.count_part = rows_ok;
                xor_result.error      = rows_ok ? error_code_e'(0) : ERR_XOR_SWAP_ROW;
                swap_en               = rows_ok;
            end
            XOR_RANK: begin
                // Rows with a leading one in column 0
                xor_result.hit = 1'b1;
                xor_result.ok  = 1'b1;
                for (int r = 0; r < `THIELE_XOR_ROWS; r++) begin
                    xor_result.status = xor_result.status + rows[r].cols[0];
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Starting pattern, column 0 is bit 0
            rows[0] <= {1'b0, 6'b101001};
            rows[1] <= {1'b1, 6'b010010};
            rows[2] <= {1'b1, 6'b100100};
            rows[3] <= {1'b0, 6'b000011};
        end else if (exec_fire) begin
            if (add_en) begin
                rows[t_idx] <= rows[t_idx] ^ rows[s_idx];
            end
            if (swap_en) begin
                rows[t_idx] <= rows[s_idx];
                rows[s_idx] <= rows[t_idx];
            end
        end
    end

endmodule

//--- src/thiele_partition_table.sv
// Partition size table with PNEW, PMERGE, XFER and MDLACC
// Reports a unit result each cycle and commits on the execute strobe
`timescale 1ns/10ps
`include "thiele_macros.svh"

module thiele_partition_table import thiele_isa_pkg::*, thiele_result_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  instr_t       exec_instr,
    input  logic         exec_fire,
    output unit_result_t part_result
);

    localparam int ID_W = `THIELE_PART_ID_W;
    localparam int SZ_W = `THIELE_SIZE_W;

    logic [SZ_W-1:0]           sizes [`THIELE_NUM_PARTS];
    logic [ID_W:0]             next_id;
    logic [ID_W-1:0]           cur_id;
    logic [7:0]                id_lim;
    logic [ID_W-1:0]           a_idx, b_idx, n_idx, m_idx;
    logic                      a_ok, b_ok, m_ok, space;
    logic [SZ_W-1:0]           sa, sb, sm, merge_sum;
    // Commit controls
    logic                      wr_en, clr_en, alloc;
    logic [ID_W-1:0]           wr_idx;
    logic [SZ_W-1:0]           wr_val;

    // Bit length of a size, 0 for 0
    function automatic logic [4:0] bit_len(input logic [SZ_W-1:0] v);
        logic [4:0] n;
        n = '0;
        for (int i = 0; i < SZ_W; i++) begin
            if (v[i]) n = 5'(i + 1);
        end
        return n;
    endfunction

    // Id checks against the allocation pointer
    assign id_lim    = 8'(next_id);
    assign a_idx     = exec_instr.op_a[ID_W-1:0];
    assign b_idx     = exec_instr.op_b[ID_W-1:0];
    assign n_idx     = next_id[ID_W-1:0];
    assign a_ok      = exec_instr.op_a < id_lim;
    assign b_ok      = exec_instr.op_b < id_lim;
    assign space     = next_id < `THIELE_NUM_PARTS;
    // MDLACC id 0 selects the current partition
    assign m_ok      = (exec_instr.op_a == 8'd0) || a_ok;
    assign m_idx     = (exec_instr.op_a == 8'd0) ? cur_id : a_idx;
    assign sa        = sizes[a_idx];
    assign sb        = sizes[b_idx];
    assign sm        = sizes[m_idx];
    assign merge_sum = sa + sb;

    // ==========================================================
    // Result and commit decode
    // ==========================================================
    always_comb begin
        part_result = '0;
        wr_en       = 1'b0;
        clr_en      = 1'b0;
        alloc       = 1'b0;
        wr_idx      = n_idx;
        wr_val      = SZ_W'({exec_instr.op_a, exec_instr.op_b});
        case (exec_instr.opcode)
            PNEW: begin
                part_result.hit = 1'b1;
                if (space) begin
                    part_result.ok         = 1'b1;
                    part_result.status     = PNEW_OK;
                    part_result.count_part = 1'b1;
                    wr_en                  = 1'b1;
                    alloc                  = 1'b1;
                end else begin
                    part_result.error = ERR_TABLE_FULL;
                end
            end
            PMERGE: begin
                part_result.hit = 1'b1;
                wr_val          = merge_sum;
                if (!a_ok || !b_ok || a_idx == b_idx || !space) begin
                    part_result.error = ERR_MERGE_ID;
                end else if (merge_sum > `THIELE_REGION_LIMIT) begin
                    part_result.error = ERR_MERGE_SIZE;
                end else begin
                    part_result.ok         = 1'b1;
                    part_result.status     = MERGE_OK;
                    part_result.count_part = 1'b1;
                    wr_en                  = 1'b1;
                    clr_en                 = 1'b1;
                    alloc                  = 1'b1;
                end
            end
            XFER: begin
                part_result.hit = 1'b1;
                wr_idx          = b_idx;
                wr_val          = sb + 1'b1;
                if (!a_ok || !b_ok) begin
                    part_result.error = ERR_XFER_ID;
                end else if (sa != '0 && sb < `THIELE_REGION_LIMIT) begin
                    part_result.ok     = 1'b1;
                    part_result.status = XFER_OK;
                    wr_en              = 1'b1;
                end else begin
                    part_result.error = ERR_XFER;
                end
            end
            MDLACC: begin
                part_result.hit = 1'b1;
                if (m_ok) begin
                    // Overflow against the accumulator is judged in the CSR bank
                    part_result.ok         = 1'b1;
                    part_result.status     = MDL_OK;
                    part_result.cost_valid = 1'b1;
                    part_result.cost       = (sm == '0) ? 32'd1 :
                        `THIELE_WORD_W'(bit_len(sm)) * `THIELE_WORD_W'(sm);
                end else begin
                    part_result.error = ERR_MDL_ID;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `THIELE_NUM_PARTS; i++) begin
                sizes[i] <= '0;
            end
            next_id <= 1;
            cur_id  <= '0;
        end else if (exec_fire) begin
            if (clr_en) begin
                sizes[a_idx] <= '0;
                sizes[b_idx] <= '0;
            end
            if (wr_en) begin
                sizes[wr_idx] <= wr_val;
            end
            if (alloc) begin
                cur_id  <= n_idx;
                next_id <= next_id + 1'b1;
            end
        end
    end

endmodule

//--- src/thiele_control.sv
// Fetch/decode/execute sequencer with pc and instruction register
// Broadcasts the instruction to the units and runs the logic engine handshakes
`timescale 1ns/10ps
`include "thiele_macros.svh"

module thiele_control import thiele_isa_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`THIELE_WORD_W-1:0] instr_data,
    output logic [`THIELE_WORD_W-1:0] pc,
    output instr_t                    exec_instr,
    output logic                      exec_fire,
    output logic                      opcode_err,
    output logic                      cert_we,
    output logic [`THIELE_WORD_W-1:0] cert_data,
    output logic                      logic_req_valid,
    input  logic                      logic_req_ready,
    output logic [`THIELE_WORD_W-1:0] logic_addr,
    input  logic                      logic_rsp_valid,
    output logic                      logic_rsp_ready,
    input  logic [`THIELE_WORD_W-1:0] logic_data
);

    ctrl_state_e               state;
    instr_t                    ir;
    logic                      known_op;
    logic [`THIELE_WORD_W-1:0] pc_next;

    assign pc_next = pc + 4;

    // ==========================================================
    // Sequencer
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FETCH;
            pc    <= '0;
        end else begin
            case (state)
                FETCH:   state <= DECODE;
                DECODE:  state <= EXECUTE;
                EXECUTE: begin
                    // LASSERT retires only after the engine answers
                    if (ir.opcode == LASSERT) begin
                        state <= LOGIC_REQ;
                    end else begin
                        pc    <= pc_next;
                        state <= FETCH;
                    end
                end
                LOGIC_REQ: begin
                    if (logic_req_ready) begin
                        state <= LOGIC_WAIT;
                    end
                end
                LOGIC_WAIT: begin
                    if (logic_rsp_valid) begin
                        pc    <= pc_next;
                        state <= FETCH;
                    end
                end
                default: state <= FETCH;
            endcase
        end
    end

    // Instruction register, loaded at the end of FETCH
    always_ff @(posedge clk) begin
        if (state == FETCH) begin
            ir <= instr_t'(instr_data);
        end
    end

    // Opcode legality, the only place unknown opcodes are detected
    always_comb begin
        case (ir.opcode)
            PNEW, PMERGE, LASSERT, MDLACC, XFER,
            XOR_ADD, XOR_SWAP, XOR_RANK, EMIT: known_op = 1'b1;
            default:                           known_op = 1'b0;
        endcase
    end

    // ==========================================================
    // Unit broadcast and logic engine
    // ==========================================================
    assign exec_instr = ir;
    assign exec_fire  = (state == EXECUTE);
    assign opcode_err = exec_fire && !known_op;

    // Request held stable straight from state and ir
    assign logic_req_valid = (state == LOGIC_REQ);
    assign logic_addr      = {{(`THIELE_WORD_W-16){1'b0}}, ir.op_a, ir.op_b};

    // Response accepted only while waiting
    assign logic_rsp_ready = (state == LOGIC_WAIT);
    assign cert_we         = logic_rsp_ready && logic_rsp_valid;
    assign cert_data       = logic_data;

endmodule

//--- src/thiele_result_pkg.sv
// Result types returned by the execution units to the CSR bank
// Status and error encodings as seen on the status outputs
`include "thiele_macros.svh"

package thiele_result_pkg;

    // Success codes written to the status register
    typedef enum logic [`THIELE_WORD_W-1:0] {
        PNEW_OK     = 32'd1,
        MERGE_OK    = 32'd3,
        MDL_OK      = 32'd5,
        XFER_OK     = 32'd6,
        XOR_ADD_OK  = 32'd8,
        XOR_SWAP_OK = 32'd9
    } status_code_e;

    // Failure codes written to the error register
    typedef enum logic [`THIELE_WORD_W-1:0] {
        ERR_OPCODE       = 32'h1,
        ERR_TABLE_FULL   = 32'h2,
        ERR_MERGE_SIZE   = 32'h4,
        ERR_MERGE_ID     = 32'h5,
        ERR_MU_OVERFLOW  = 32'h6,
        ERR_MDL_ID       = 32'h7,
        ERR_XFER         = 32'h8,
        ERR_XFER_ID      = 32'h9,
        ERR_XOR_ADD_ROW  = 32'hA,
        ERR_XOR_SWAP_ROW = 32'hB
    } error_code_e;

    // One unit's verdict on the instruction in EXECUTE
    typedef struct packed {
        logic                       hit;
        logic                       ok;
        logic [`THIELE_WORD_W-1:0]  status;
        error_code_e                error;
        logic                       count_part;
        logic                       cost_valid;
        logic [`THIELE_WORD_W-1:0]  cost;
    } unit_result_t;

endpackage

//--- src/thiele_isa_pkg.sv
// Instruction set types: opcodes, instruction word layout, sequencer states
// Imported by control, the execution units and the top level
package thiele_isa_pkg;

    // Supported opcodes, anything else counts as unknown
    typedef enum logic [7:0] {
        PNEW     = 8'h00,
        PMERGE   = 8'h02,
        LASSERT  = 8'h03,
        MDLACC   = 8'h05,
        XFER     = 8'h07,
        XOR_ADD  = 8'h0B,
        XOR_SWAP = 8'h0C,
        XOR_RANK = 8'h0D,
        EMIT     = 8'h0E
    } opcode_e;

    // Instruction word, opcode in the top byte
    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] op_a;
        logic [7:0] op_b;
        logic [7:0] rsvd;
    } instr_t;

    // Sequencer states
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        LOGIC_REQ,
        LOGIC_WAIT
    } ctrl_state_e;

endpackage

//--- src/thiele_macros.svh
// Sizing macros for the partition bookkeeping processor
// Include in any file that needs word, table or matrix dimensions
`ifndef THIELE_MACROS_SVH
`define THIELE_MACROS_SVH

// Data word and counter width
`define THIELE_WORD_W 32

// Partition table depth and id width
`define THIELE_NUM_PARTS 16
`define THIELE_PART_ID_W 4

// Size entry width, wide enough for the sum of two PNEW sizes
`define THIELE_SIZE_W 17

// Largest size allowed after merge or transfer
`define THIELE_REGION_LIMIT 1024

// XOR matrix shape
`define THIELE_XOR_ROWS 4
`define THIELE_XOR_COLS 6

`endif
